// File: cpuPkg.sv
package cpuPkg;

    localparam int DATA_W  = 32;
    localparam int PADDR_W = 12;               // APB word address width

    // Instruction word layout
    //   opcode 31:27, ra 26:23, rb 22:19, rc 18:15, C 18:0
    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opShl  = 5'd7,
        opShr  = 5'd8,
        opAddi = 5'd9,
        opIn   = 5'd10,
        opOut  = 5'd11,
        opHalt = 5'd12
    } opcode_t;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluShl, aluShr, aluPassB
    } aluOp_t;

    typedef enum logic [2:0] {
        srcNone, srcReg, srcPc, srcZ, srcMdr, srcInPort, srcConst
    } busSrc_t;

    ////////////////////////////////////////
    // Control word issued once per step
    ////////////////////////////////////////
    typedef struct packed {
        busSrc_t busSrc;
        aluOp_t  aluOp;
        logic    pcIn;
        logic    irIn;
        logic    yIn;
        logic    zIn;
        logic    marIn;
        logic    mdrIn;
        logic    outPortIn;
        logic    incPc;                        // Z takes PC+1 instead of ALU result
        logic    memRead;
        logic    memWrite;
        logic    gra;
        logic    grb;
        logic    grc;
        logic    rin;
        logic    baOut;                        // R0 reads as zero
    } ctrlWord_t;

    typedef struct packed {
        logic               psel;
        logic               penable;
        logic               pwrite;
        logic [PADDR_W-1:0] paddr;
        logic [DATA_W-1:0]  pwdata;
    } apbReq_t;

    typedef struct packed {
        logic              pready;
        logic              pslverr;
        logic [DATA_W-1:0] prdata;
    } apbRsp_t;

endpackage

// File: regFile.sv
module regFile import cpuPkg::*; (
    input  logic              clk,
    input  logic              rstN,
    input  logic [DATA_W-1:0] ir,
    input  ctrlWord_t         ctrl,
    input  logic [DATA_W-1:0] busIn,
    output logic [DATA_W-1:0] regOut
);

    logic [DATA_W-1:0] regs [16];
    logic [3:0]        ra;
    logic [3:0]        rb;
    logic [3:0]        rc;
    logic [3:0]        sel;

    assign ra = ir[26:23];
    assign rb = ir[22:19];
    assign rc = ir[18:15];

    // Select and encode, only one of gra/grb/grc is set per step
    assign sel = ({4{ctrl.gra}} & ra) | ({4{ctrl.grb}} & rb) | ({4{ctrl.grc}} & rc);

    always_comb begin
        if (ctrl.baOut && sel == 4'd0) begin
            regOut = '0;                       // Base address of zero
        end else begin
            regOut = regs[sel];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.rin) begin
            regs[sel] <= busIn;
        end
    end

endmodule

// File: alu.sv
module alu import cpuPkg::*; (
    input  logic [DATA_W-1:0] a,
    input  logic [DATA_W-1:0] b,
    input  aluOp_t            op,
    output logic [DATA_W-1:0] result
);

    logic [4:0] shamt;

    // Shift count is b modulo 32
    assign shamt = b[4:0];

    ////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////
    always_comb begin
        case (op)
            aluAdd: begin
                result = a + b;
            end
            aluSub: begin
                result = a - b;
            end
            aluAnd: begin
                result = a & b;
            end
            aluOr: begin
                result = a | b;
            end
            aluShl: begin
                result = a << shamt;
            end
            aluShr: begin
                result = a >> shamt;               // Logical shift
            end
            aluPassB: begin
                result = b;
            end
            default: begin
                result = b;
            end
        endcase
    end

endmodule

// File: wordMemory.sv
module wordMemory import cpuPkg::*; #(
    parameter  int MEM_DEPTH = 512,
    localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic [ADDR_W-1:0] addr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              read,
    input  logic              write,
    output logic [DATA_W-1:0] rdata,
    input  logic              halted,
    input  apbReq_t           apbIn,
    output apbRsp_t           apbOut
);

    logic [DATA_W-1:0] mem [MEM_DEPTH];
    logic [DATA_W-1:0] apbRdata;
    logic [ADDR_W-1:0] apbIdx;
    logic              apbReady;
    logic              apbErr;
    logic              apbValid;
    logic              apbAccess;

    assign apbIdx   = apbIn.paddr[ADDR_W-1:0];
    assign apbValid = apbIn.paddr < MEM_DEPTH;
    // Access phase only starts once the CPU is stopped
    assign apbAccess = apbIn.psel && apbIn.penable && halted && !apbReady;

    ////////////////////////////////////////
    // Array, CPU port while running and APB port while halted
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!halted) begin
            if (write) begin
                mem[addr] <= wdata;
            end
            if (read) begin
                rdata <= mem[addr];            // One cycle read latency
            end
        end else if (apbAccess) begin
            if (!apbValid) begin
                apbRdata <= '0;
            end else if (apbIn.pwrite) begin
                mem[apbIdx] <= apbIn.pwdata;
            end else begin
                apbRdata <= mem[apbIdx];
            end
        end
    end

    // pready is high for exactly one cycle per transfer
    always_ff @(posedge clk) begin
        if (!rstN) begin
            apbReady <= 1'b0;
            apbErr   <= 1'b0;
        end else if (apbReady) begin
            apbReady <= 1'b0;
            apbErr   <= 1'b0;
        end else if (apbAccess) begin
            apbReady <= 1'b1;
            apbErr   <= !apbValid;
        end
    end

    assign apbOut.pready  = apbReady;
    assign apbOut.pslverr = apbErr;
    assign apbOut.prdata  = apbRdata;

endmodule

// File: dataPath.sv
module dataPath import cpuPkg::*; #(
    parameter  int MEM_DEPTH = 512,
    localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    input  ctrlWord_t         ctrl,
    input  logic [DATA_W-1:0] memRdata,
    output logic [ADDR_W-1:0] memAddr,
    output logic [DATA_W-1:0] memWdata,
    output opcode_t           opcode,
    input  logic [DATA_W-1:0] inPort,
    output logic [DATA_W-1:0] outPort
);

    logic [DATA_W-1:0] busData;
    logic [DATA_W-1:0] regOut;
    logic [DATA_W-1:0] aluResult;
    logic [DATA_W-1:0] constC;
    logic [DATA_W-1:0] mdrView;
    logic [DATA_W-1:0] pc;
    logic [DATA_W-1:0] ir;
    logic [DATA_W-1:0] y;
    logic [DATA_W-1:0] z;
    logic [DATA_W-1:0] mdr;
    logic [DATA_W-1:0] inReg;
    logic [ADDR_W-1:0] mar;
    logic              mdrLoadMem;

    regFile uRegFile (
        .clk    (clk),
        .rstN   (rstN),
        .ir     (ir),
        .ctrl   (ctrl),
        .busIn  (busData),
        .regOut (regOut)
    );

    alu uAlu (
        .a      (y),
        .b      (busData),
        .op     (ctrl.aluOp),
        .result (aluResult)
    );

    assign constC = {{(DATA_W-19){ir[18]}}, ir[18:0]};   // Sign-extended C field
    assign opcode = opcode_t'(ir[31:27]);

    // Memory word arrives the step after the read, so MDR forwards it then
    assign mdrView = mdrLoadMem ? memRdata : mdr;

    ////////////////////////////////////////
    // Bus multiplexer
    ////////////////////////////////////////
    always_comb begin
        case (ctrl.busSrc)
            srcReg:    busData = regOut;
            srcPc:     busData = pc;
            srcZ:      busData = z;
            srcMdr:    busData = mdrView;
            srcInPort: busData = inReg;
            srcConst:  busData = constC;
            default:   busData = '0;
        endcase
    end

    // Control registers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc         <= '0;
            ir         <= '0;
            outPort    <= '0;
            mdrLoadMem <= 1'b0;
        end else begin
            if (start) begin
                pc <= '0;
            end else if (ctrl.pcIn) begin
                pc <= busData;
            end
            if (ctrl.irIn) begin
                ir <= busData;
            end
            if (ctrl.outPortIn) begin
                outPort <= busData;
            end
            mdrLoadMem <= ctrl.mdrIn && ctrl.memRead;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        inReg <= inPort;
        if (ctrl.yIn) begin
            y <= busData;
        end
        if (ctrl.zIn) begin
            z <= ctrl.incPc ? pc + 1 : aluResult;
        end
        if (ctrl.marIn) begin
            mar <= busData[ADDR_W-1:0];
        end
        if (mdrLoadMem) begin
            mdr <= memRdata;
        end else if (ctrl.mdrIn && !ctrl.memRead) begin
            mdr <= busData;
        end
    end

    assign memAddr  = mar;
    assign memWdata = ctrl.mdrIn ? busData : mdr;   // st writes in the same step as MDR load

endmodule

// File: controlUnit.sv
module controlUnit import cpuPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      start,
    input  opcode_t   opcode,
    output ctrlWord_t ctrl,
    output logic      halted
);

    typedef enum logic [3:0] {
        sIdle, sT0, sT1, sT2, sT3, sT4, sT5, sT6, sT7
    } state_t;

    state_t state;
    state_t nextState;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    assign halted = (state == sIdle);

    ////////////////////////////////////////
    // Step decode
    ////////////////////////////////////////
    always_comb begin
        ctrl      = '0;
        nextState = state;
        case (state)
            sIdle: begin
                if (start) begin
                    nextState = sT0;
                end
            end
            sT0: begin                         // PC to MAR, Z gets PC+1
                ctrl.busSrc = srcPc;
                ctrl.marIn  = 1'b1;
                ctrl.incPc  = 1'b1;
                ctrl.zIn    = 1'b1;
                nextState   = sT1;
            end
            sT1: begin                         // Z to PC, fetch word
                ctrl.busSrc  = srcZ;
                ctrl.pcIn    = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.mdrIn   = 1'b1;
                nextState    = sT2;
            end
            sT2: begin
                ctrl.busSrc = srcMdr;
                ctrl.irIn   = 1'b1;
                nextState   = sT3;
            end
            sT3: begin
                nextState = sT4;
                case (opcode)
                    opLd, opLdi, opSt, opAddi: begin
                        ctrl.busSrc = srcReg;  // Base register into Y
                        ctrl.grb    = 1'b1;
                        ctrl.baOut  = 1'b1;
                        ctrl.yIn    = 1'b1;
                    end
                    opAdd, opSub, opAnd, opOr, opShl, opShr: begin
                        ctrl.busSrc = srcReg;
                        ctrl.grb    = 1'b1;
                        ctrl.yIn    = 1'b1;
                    end
                    opIn: begin
                        ctrl.busSrc = srcInPort;
                        ctrl.gra    = 1'b1;
                        ctrl.rin    = 1'b1;
                        nextState   = sT0;
                    end
                    opOut: begin
                        ctrl.busSrc    = srcReg;
                        ctrl.gra       = 1'b1;
                        ctrl.outPortIn = 1'b1;
                        nextState      = sT0;
                    end
                    opHalt: begin
                        nextState = sIdle;
                    end
                    default: begin
                        nextState = sT0;       // Unknown opcode runs as a no-op
                    end
                endcase
            end
            sT4: begin
                ctrl.zIn  = 1'b1;
                nextState = sT5;
                if (opcode == opLd || opcode == opLdi || opcode == opSt || opcode == opAddi) begin
                    ctrl.busSrc = srcConst;
                    ctrl.aluOp  = aluAdd;
                end else begin
                    ctrl.busSrc = srcReg;
                    ctrl.grc    = 1'b1;
                    case (opcode)
                        opSub:   ctrl.aluOp = aluSub;
                        opAnd:   ctrl.aluOp = aluAnd;
                        opOr:    ctrl.aluOp = aluOr;
                        opShl:   ctrl.aluOp = aluShl;
                        opShr:   ctrl.aluOp = aluShr;
                        default: ctrl.aluOp = aluAdd;
                    endcase
                end
            end
            sT5: begin
                ctrl.busSrc = srcZ;
                if (opcode == opLd || opcode == opSt) begin
                    ctrl.marIn = 1'b1;         // Effective address
                    nextState  = sT6;
                end else begin
                    ctrl.gra  = 1'b1;
                    ctrl.rin  = 1'b1;
                    nextState = sT0;
                end
            end
            sT6: begin
                ctrl.mdrIn = 1'b1;
                if (opcode == opSt) begin
                    ctrl.busSrc   = srcReg;
                    ctrl.gra      = 1'b1;
                    ctrl.memWrite = 1'b1;
                    nextState     = sT0;
                end else begin
                    ctrl.memRead = 1'b1;
                    nextState    = sT7;
                end
            end
            sT7: begin                         // Loaded word into Ra
                ctrl.busSrc = srcMdr;
                ctrl.gra    = 1'b1;
                ctrl.rin    = 1'b1;
                nextState   = sT0;
            end
            default: begin
                nextState = sIdle;
            end
        endcase
    end

endmodule

// File: cpuTop.sv
module cpuTop import cpuPkg::*; #(
    parameter  int MEM_DEPTH = 512,
    localparam int ADDR_W    = $clog2(MEM_DEPTH)
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              start,
    output logic              halted,
    input  logic [DATA_W-1:0] inPort,
    output logic [DATA_W-1:0] outPort,
    input  apbReq_t           apbIn,
    output apbRsp_t           apbOut
);

    ctrlWord_t         ctrl;
    opcode_t           opcode;
    logic [ADDR_W-1:0] memAddr;
    logic [DATA_W-1:0] memWdata;
    logic [DATA_W-1:0] memRdata;
    logic              runStart;

    assign runStart = start && halted;         // PC clears only on an accepted start

    controlUnit uControl (
        .clk    (clk),
        .rstN   (rstN),
        .start  (start),
        .opcode (opcode),
        .ctrl   (ctrl),
        .halted (halted)
    );

    dataPath #(.MEM_DEPTH(MEM_DEPTH)) uDataPath (
        .clk      (clk),
        .rstN     (rstN),
        .start    (runStart),
        .ctrl     (ctrl),
        .memRdata (memRdata),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .opcode   (opcode),
        .inPort   (inPort),
        .outPort  (outPort)
    );

    wordMemory #(.MEM_DEPTH(MEM_DEPTH)) uMemory (
        .clk    (clk),
        .rstN   (rstN),
        .addr   (memAddr),
        .wdata  (memWdata),
        .read   (ctrl.memRead),
        .write  (ctrl.memWrite),
        .rdata  (memRdata),
        .halted (halted),
        .apbIn  (apbIn),
        .apbOut (apbOut)
    );

endmodule

// File: tbCpuTasks.sv
package tbCpuTasks;
    import cpuPkg::*;

    localparam int MODEL_DEPTH = 512;

    logic [31:0] lfsrState = 32'h88d02ff5;
    logic [31:0] modelRegs [16];
    logic [31:0] modelMem [MODEL_DEPTH];
    logic [31:0] modelOuts [$];                // Expected outPort values, oldest first

    // Galois LFSR, one step per bit
    function automatic logic nextBit();
        logic lsb;
        lsb = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (lsb) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] randBits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], nextBit()};
        end
        return r;
    endfunction

    ////////////////////////////////////////
    // Instruction encoders
    ////////////////////////////////////////
    function automatic logic [31:0] encR(opcode_t op, logic [3:0] ra, logic [3:0] rb,
                                         logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [31:0] encI(opcode_t op, logic [3:0] ra, logic [3:0] rb,
                                         logic [18:0] c);
        return {op, ra, rb, c};
    endfunction

    function automatic void modelReset();
        for (int i = 0; i < 16; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < MODEL_DEPTH; i++) begin
            modelMem[i] = '0;
        end
    endfunction

    // Instruction-level model of the program in modelMem, starting at word 0
    function automatic void modelRun(logic [31:0] inVal);
        logic [31:0] pc;
        logic [31:0] ir;
        logic [31:0] c;
        logic [31:0] base;
        logic [31:0] addr;
        logic [31:0] bVal;
        logic [31:0] cVal;
        logic [3:0]  ra;
        logic [3:0]  rb;
        int          steps;
        bit          done;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            ir    = modelMem[pc[8:0]];
            pc    = pc + 32'd1;
            ra    = ir[26:23];
            rb    = ir[22:19];
            c     = {{13{ir[18]}}, ir[18:0]};
            bVal  = modelRegs[rb];
            cVal  = modelRegs[ir[18:15]];
            base  = (rb == 4'd0) ? 32'd0 : bVal;   // R0 as base reads zero
            addr  = base + c;
            steps = steps + 1;
            case (opcode_t'(ir[31:27]))
                opLdi, opAddi: modelRegs[ra] = addr;
                opLd:   modelRegs[ra] = modelMem[addr[8:0]];
                opSt:   modelMem[addr[8:0]] = modelRegs[ra];
                opAdd:  modelRegs[ra] = bVal + cVal;
                opSub:  modelRegs[ra] = bVal - cVal;
                opAnd:  modelRegs[ra] = bVal & cVal;
                opOr:   modelRegs[ra] = bVal | cVal;
                opShl:  modelRegs[ra] = bVal << cVal[4:0];
                opShr:  modelRegs[ra] = bVal >> cVal[4:0];
                opIn:   modelRegs[ra] = inVal;
                opOut:  modelOuts.push_back(modelRegs[ra]);
                opHalt: done = 1'b1;
                default: ;
            endcase
        end
    endfunction

endpackage

// File: tbCpu.sv
module tbCpu import cpuPkg::*, tbCpuTasks::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_DEPTH       = 512;
    localparam int NUM_PROGRAMS    = 4;
    localparam int WATCHDOG_CYCLES = NUM_PROGRAMS * 2000;
    localparam int WAIT_LIMIT      = 1500;

    logic        clk;
    logic        rstN;
    logic        start;
    logic        halted;
    logic [31:0] inPort;
    logic [31:0] outPort;
    apbReq_t     apbReq;
    apbRsp_t     apbRsp;
    logic [31:0] progWords [$];
    bit          outPending;

    cpuTop #(.MEM_DEPTH(MEM_DEPTH)) dut0 (
        .clk     (clk),
        .rstN    (rstN),
        .start   (start),
        .halted  (halted),
        .inPort  (inPort),
        .outPort (outPort),
        .apbIn   (apbReq),
        .apbOut  (apbRsp)
    );

    always #5 clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * 10);
        $display("ERROR: watchdog expired, the run did not finish in time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog");
    end

    task automatic stopRun();
        $display("STATUS: FAIL");
        $fatal(1, "check failed");
    endtask

    task automatic reportFailure(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stopRun();
    endtask

    task automatic checkValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, exp, act);
            stopRun();
        end
    endtask

    // No APB transfer may complete while the CPU runs
    assert property (@(posedge clk) disable iff (!rstN) !halted |-> !apbRsp.pready) else begin
        $display("MISMATCH at %0t: pready expected 0 actual 1", $time);
        stopRun();
    end

    // outPort is loaded the step after outPortIn, so compare one cycle later
    always @(negedge clk) begin
        if (outPending) begin
            if (modelOuts.size() == 0) begin
                reportFailure("outPort written more often than the program outputs");
            end else begin
                checkValue("outPort", modelOuts.pop_front(), outPort);
            end
        end
        outPending = rstN && dut0.ctrl.outPortIn;
    end

    ////////////////////////////////////////
    // APB and program tasks
    ////////////////////////////////////////
    task automatic apbXfer(input logic write, input logic [11:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
        int waitCycles;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = write;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(posedge clk);
        #1 apbReq.penable = 1'b1;
        waitCycles = 0;
        do begin
            @(posedge clk);
            #1 waitCycles++;
        end while (!apbRsp.pready && waitCycles < WAIT_LIMIT);
        if (!apbRsp.pready) begin
            reportFailure("APB transfer never completed");
        end
        rdata = apbRsp.prdata;
        err   = apbRsp.pslverr;
        @(posedge clk);                        // Completing cycle
        #1 apbReq = '0;
    endtask

    task automatic loadProgram();
        logic [31:0] rd;
        logic        err;
        for (int i = 0; i < progWords.size(); i++) begin
            apbXfer(1'b1, 12'(i), progWords[i], rd, err);
            checkValue("pslverr", 32'd0, {31'd0, err});
            modelMem[i] = progWords[i];
        end
    endtask

    task automatic launchProgram(input logic [31:0] inVal);
        inPort = inVal;
        modelRun(inVal);
        start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        checkValue("halted", 32'd0, {31'd0, halted});
    endtask

    task automatic waitHalted();
        int waitCycles;
        waitCycles = 0;
        while (!halted && waitCycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1 waitCycles++;
        end
        if (!halted) begin
            reportFailure("CPU did not halt");
        end
        repeat (2) @(posedge clk);
        #1 checkValue("pending outputs", 32'd0, 32'(modelOuts.size()));
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial begin
        logic [31:0] rd;
        logic [31:0] val;
        logic        err;
        logic [18:0] addr;
        clk = 1'b0;
        rstN = 1'b0;
        start = 1'b0;
        inPort = '0;
        apbReq = '0;
        modelReset();
        repeat (16) @(posedge clk);
        #1 rstN = 1'b1;
        checkValue("halted", 32'd1, {31'd0, halted});
        checkValue("outPort", 32'd0, outPort);
        checkValue("pready", 32'd0, {31'd0, apbRsp.pready});

        // APB write and read back
        val = randBits(32);
        apbXfer(1'b1, 12'd300, val, rd, err);
        apbXfer(1'b0, 12'd300, 32'd0, rd, err);
        checkValue("prdata", val, rd);
        modelMem[300] = val;
        apbXfer(1'b0, 12'h400, 32'd0, rd, err);       // Beyond MEM_DEPTH
        checkValue("pslverr", 32'd1, {31'd0, err});

        // ALU program
        progWords = {encI(opLdi, 4'd1, 4'd0, 19'(randBits(19))), encR(opOut, 4'd1, 4'd0, 4'd0),
                     encI(opLdi, 4'd2, 4'd0, 19'(randBits(19))), encR(opOut, 4'd2, 4'd0, 4'd0),
                     encI(opAddi, 4'd3, 4'd1, 19'(randBits(19))), encR(opOut, 4'd3, 4'd0, 4'd0),
                     encR(opAdd, 4'd4, 4'd1, 4'd2), encR(opOut, 4'd4, 4'd0, 4'd0),
                     encR(opSub, 4'd4, 4'd1, 4'd2), encR(opOut, 4'd4, 4'd0, 4'd0),
                     encR(opAnd, 4'd4, 4'd1, 4'd2), encR(opOut, 4'd4, 4'd0, 4'd0),
                     encR(opOr, 4'd4, 4'd1, 4'd2), encR(opOut, 4'd4, 4'd0, 4'd0),
                     encR(opShl, 4'd4, 4'd1, 4'd2), encR(opOut, 4'd4, 4'd0, 4'd0),
                     encR(opShr, 4'd4, 4'd1, 4'd2), encR(opOut, 4'd4, 4'd0, 4'd0),
                     encR(opHalt, 4'd0, 4'd0, 4'd0)};
        loadProgram();
        launchProgram(32'd0);
        waitHalted();

        // Store then load, value built as (c1 << 13) + c2
        addr = 19'(32'd256 + randBits(8));
        progWords = {encI(opLdi, 4'd5, 4'd0, 19'(randBits(19))), encI(opLdi, 4'd10, 4'd0, 19'd13),
                     encR(opShl, 4'd5, 4'd5, 4'd10), encI(opAddi, 4'd5, 4'd5, 19'(randBits(19))),
                     encI(opSt, 4'd5, 4'd0, addr), encI(opLd, 4'd6, 4'd0, addr),
                     encR(opOut, 4'd6, 4'd0, 4'd0), encR(opHalt, 4'd0, 4'd0, 4'd0)};
        loadProgram();
        launchProgram(32'd0);
        waitHalted();
        apbXfer(1'b0, 12'(addr), 32'd0, rd, err);
        checkValue("memory word", modelMem[addr[8:0]], rd);

        // in/out, then R0 holds a value but still reads zero as a base
        progWords = {encR(opIn, 4'd0, 4'd0, 4'd0), encR(opOut, 4'd0, 4'd0, 4'd0),
                     encI(opLdi, 4'd8, 4'd0, 19'(randBits(19))), encR(opOut, 4'd8, 4'd0, 4'd0),
                     encR(opHalt, 4'd0, 4'd0, 4'd0)};
        loadProgram();
        launchProgram(randBits(32) | 32'h8000_0000);
        waitHalted();

        // APB read held off by a running program
        addr = 19'(32'd256 + randBits(8));
        progWords = {encI(opLdi, 4'd9, 4'd0, 19'(randBits(19))), encI(opSt, 4'd9, 4'd0, addr),
                     encR(opOut, 4'd9, 4'd0, 4'd0), encR(opHalt, 4'd0, 4'd0, 4'd0)};
        loadProgram();
        launchProgram(32'd0);
        fork
            waitHalted();
            apbXfer(1'b0, 12'(addr), 32'd0, rd, err);
        join
        checkValue("memory word", modelMem[addr[8:0]], rd);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: verilog.f
cpuPkg.sv
regFile.sv
alu.sv
wordMemory.sv
dataPath.sv
controlUnit.sv
cpuTop.sv
tbCpuTasks.sv
tbCpu.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tbCpu
OBJ_DIR   ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_MSG  ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
